// File: rtl/memPkg.sv
package memPkg;

	////////////////////
	// Data path widths
	////////////////////

	// Machine word
	localparam int dataWidth = 32;
	// One byte lane
	localparam int byteWidth = 8;
	// One halfword lane
	localparam int halfWidth = 16;
	// Byte lanes per word
	localparam int byteLanes = dataWidth / byteWidth;

	////////////////////
	// Encodings
	////////////////////

	// Access size and sign of a load or store
	// Stores ignore the sign so the U variants store like the signed ones
	typedef enum logic [2:0] {
		modeWord,
		modeHalf,
		modeHalfU,
		modeByte,
		modeByteU
	} accessMode_t;

	// What a result packet carries to the register file side
	typedef enum logic [1:0] {
		wbNone,
		wbLoad,
		wbDebug,
		wbFault
	} wbKind_t;

	////////////////////
	// Packets
	////////////////////

	// One pipeline request, sampled every cycle
	typedef struct packed {
		logic read;
		logic write;
		accessMode_t mode;
		// Byte address, word index from the upper bits
		logic [31:0] byteAddr;
		logic [dataWidth-1:0] writeData;
		logic [4:0] destReg;
	} memReq_t;

	// One result toward writeback
	typedef struct packed {
		wbKind_t kind;
		logic [4:0] destReg;
		logic [dataWidth-1:0] data;
	} wbPacket_t;

endpackage

// File: rtl/storeAligner.sv
module storeAligner (
	input memPkg::accessMode_t mode,
	input logic [1:0] offset,
	input logic [memPkg::dataWidth-1:0] writeData,
	output logic [memPkg::dataWidth-1:0] laneData,
	output logic [3:0] byteEnable
);
	import memPkg::*;

	// Lane placement and byte enables
	always_comb begin
		case (mode)
			modeByte, modeByteU: begin
				// Low byte copied into every lane
				laneData = {byteLanes{writeData[byteWidth-1:0]}};
				// Only the addressed lane
				byteEnable = 4'b0001 << offset;
			end
			modeHalf, modeHalfU: begin
				// Low half copied into both halves
				laneData = {(byteLanes / 2){writeData[halfWidth-1:0]}};
				// Upper or lower pair by offset bit 1
				byteEnable = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				// Whole word
				laneData = writeData;
				byteEnable = 4'b1111;
			end
		endcase
	end

	////////////////////
	// Checks
	////////////////////

	// Only single lanes, aligned pairs or the full word
	always_comb begin
		if (!$isunknown({mode, offset})) begin
			assert (byteEnable inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
				4'b0011, 4'b1100, 4'b1111})
			else
				$error("storeAligner: illegal byte enable %b", byteEnable);
		end
	end

endmodule

// File: rtl/loadExtractor.sv
module loadExtractor (
	input memPkg::accessMode_t mode,
	input logic [1:0] offset,
	input logic [memPkg::dataWidth-1:0] readWord,
	output logic [memPkg::dataWidth-1:0] loadData
);
	import memPkg::*;

	// Lane picked out of the read word
	logic [byteWidth-1:0] byteLane;
	logic [halfWidth-1:0] halfLane;
	// Sign bits of each lane
	logic byteSign;
	logic halfSign;

	////////////////////
	// Lane select
	////////////////////

	// Byte lane by full offset
	assign byteLane = readWord[offset * byteWidth +: byteWidth];

	// Halfword lane by offset bit 1
	assign halfLane = offset[1] ? readWord[dataWidth-1:halfWidth] : readWord[halfWidth-1:0];

	assign byteSign = byteLane[byteWidth-1];
	assign halfSign = halfLane[halfWidth-1];

	////////////////////
	// Extension
	////////////////////

	always_comb begin
		case (mode)
			// Signed byte
			modeByte:
				loadData = {{(dataWidth - byteWidth){byteSign}}, byteLane};
			// Unsigned byte, zero fill
			modeByteU:
				loadData = {{(dataWidth - byteWidth){1'b0}}, byteLane};
			// Signed halfword
			modeHalf:
				loadData = {{(dataWidth - halfWidth){halfSign}}, halfLane};
			// Unsigned halfword
			modeHalfU:
				loadData = {{(dataWidth - halfWidth){1'b0}}, halfLane};
			// Word passes through untouched
			default:
				loadData = readWord;
		endcase
	end

endmodule

// File: rtl/dataMemory.sv
module dataMemory #(
	parameter int addrWidth = 10
) (
	input logic clk,
	input logic [addrWidth-1:0] wordAddr,
	input logic [3:0] byteEnable,
	input logic [memPkg::dataWidth-1:0] writeData,
	output logic [memPkg::dataWidth-1:0] readData
);
	import memPkg::*;

	// Word count
	localparam int depth = 1 << addrWidth;

	// Storage array, contents survive reset
	logic [dataWidth-1:0] mem [depth];

	////////////////////
	// Write port
	////////////////////

	// Each enabled lane merged at the edge
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < byteLanes; lane++) begin
			if (byteEnable[lane]) begin
				mem[wordAddr][lane * byteWidth +: byteWidth] <=
					writeData[lane * byteWidth +: byteWidth];
			end
		end
	end

	////////////////////
	// Read port
	////////////////////

	// Registered read
	// Same cycle write gives the old word here
	always_ff @(posedge clk) begin
		readData <= mem[wordAddr];
	end

	// Enables are driven low through reset by the access block
	// so an X here means a broken write path
	assert property (@(posedge clk) !$isunknown(byteEnable))
	else
		$error("dataMemory: byte enable unknown");

endmodule

// File: rtl/memAccessBlock.sv
module memAccessBlock #(
	parameter int addrWidth = 10
) (
	input logic clk,
	input logic rstN,
	input memPkg::memReq_t req,
	input logic debugMode,
	input logic [addrWidth-1:0] debugAddr,
	output memPkg::wbPacket_t result
);
	import memPkg::*;

	// Load path context held across the RAM read
	typedef struct packed {
		accessMode_t mode;
		logic [1:0] offset;
		logic [4:0] destReg;
	} memCtx_t;

	// Effective access after the debug override
	accessMode_t effMode;
	logic [1:0] effOffset;
	logic [addrWidth-1:0] wordAddr;
	logic misaligned;
	logic writeEnable;

	// Store side
	logic [dataWidth-1:0] laneData;
	logic [3:0] laneEnable;
	logic [3:0] ramEnable;

	// Load side
	logic [dataWidth-1:0] readWord;
	logic [dataWidth-1:0] loadData;

	// Context
	wbKind_t kindNext;
	wbKind_t ctxKind;
	memCtx_t ctxNext;
	memCtx_t ctx;

	////////////////////
	// Debug override
	////////////////////

	// Debug reads whole words at the monitor index
	assign effMode = debugMode ? modeWord : req.mode;
	assign effOffset = debugMode ? 2'b00 : req.byteAddr[1:0];
	assign wordAddr = debugMode ? debugAddr : req.byteAddr[addrWidth+1:2];

	// Alignment by access size
	always_comb begin
		case (effMode)
			modeHalf, modeHalfU:
				misaligned = effOffset[0];
			modeWord:
				misaligned = |effOffset;
			default:
				misaligned = 1'b0;
		endcase
	end

	// Read wins over write, debug and faults block it
	// No RAM writes while held in reset
	assign writeEnable = req.write && !req.read && !debugMode && !misaligned && rstN;

	////////////////////
	// Store and RAM
	////////////////////

	storeAligner storeAlign (
		.mode(effMode),
		.offset(effOffset),
		.writeData(req.writeData),
		.laneData(laneData),
		.byteEnable(laneEnable)
	);

	// Lanes masked off when nothing is written
	assign ramEnable = writeEnable ? laneEnable : 4'b0000;

	dataMemory #(
		.addrWidth(addrWidth)
	) ram (
		.clk(clk),
		.wordAddr(wordAddr),
		.byteEnable(ramEnable),
		.writeData(laneData),
		.readData(readWord)
	);

	////////////////////
	// Load context
	////////////////////

	// Result kind for this cycle
	always_comb begin
		if (debugMode)
			kindNext = wbDebug;
		else if ((req.read || req.write) && misaligned)
			kindNext = wbFault;
		else if (req.read)
			kindNext = wbLoad;
		else
			kindNext = wbNone;
	end

	// Debug packets carry no destination
	assign ctxNext.mode = effMode;
	assign ctxNext.offset = effOffset;
	assign ctxNext.destReg = debugMode ? 5'd0 : req.destReg;

	// Kind is control and resets
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			ctxKind <= wbNone;
		else
			ctxKind <= kindNext;
	end

	// Payload lines up with the RAM read data
	always_ff @(posedge clk) begin
		ctx <= ctxNext;
	end

	loadExtractor loadExtract (
		.mode(ctx.mode),
		.offset(ctx.offset),
		.readWord(readWord),
		.loadData(loadData)
	);

	// Data only for loads and debug reads, zero otherwise
	assign result.kind = ctxKind;
	assign result.destReg = ctx.destReg;
	assign result.data = (ctxKind == wbLoad || ctxKind == wbDebug) ? loadData : '0;

	// Debug forces aligned word reads so no fault may follow it
	assert property (@(posedge clk) disable iff (!rstN)
		(ctxKind == wbFault) |-> !$past(debugMode))
	else
		$error("memAccessBlock: fault registered during debug mode");

endmodule

// File: rtl/memWbRegister.sv
module memWbRegister (
	input logic clk,
	input logic rstN,
	input memPkg::wbPacket_t result,
	output memPkg::wbPacket_t wb
);
	import memPkg::*;

	////////////////////
	// MEM/WB boundary
	////////////////////

	// Cleared to an empty packet so the register file
	// sees no write coming out of reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wb.kind <= wbNone;
			wb.destReg <= '0;
			wb.data <= '0;
		end else begin
			wb <= result;
		end
	end

	// Faults never carry data across the boundary
	assert property (@(posedge clk) disable iff (!rstN)
		(wb.kind == wbFault) |-> (wb.data == '0))
	else
		$error("memWbRegister: fault packet with data");

endmodule

// File: rtl/memStageTop.sv
module memStageTop #(
	parameter int addrWidth = 10
) (
	input logic clk,
	input logic rstN,
	input memPkg::memReq_t req,
	input logic debugMode,
	input logic [addrWidth-1:0] debugAddr,
	output memPkg::wbPacket_t wb
);
	import memPkg::*;

	// Access block to writeback register
	wbPacket_t result;

	////////////////////
	// Access stage
	////////////////////

	memAccessBlock #(
		.addrWidth(addrWidth)
	) access (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.debugMode(debugMode),
		.debugAddr(debugAddr),
		.result(result)
	);

	////////////////////
	// Writeback
	////////////////////

	memWbRegister wbReg (
		.clk(clk),
		.rstN(rstN),
		.result(result),
		.wb(wb)
	);

endmodule

// File: bench/memStageRef.svh
`ifndef MEM_STAGE_REF_SVH
`define MEM_STAGE_REF_SVH

////////////////////
// Shadow memory
////////////////////

// Expected word contents, X until written
logic [dataWidth-1:0] shadow [1 << addrWidth];

// Mismatch counters
int kindErrors = 0;
int payloadErrors = 0;

// Halfwords need an even address, words a multiple of four
function automatic logic sizeFault(input accessMode_t mode, input logic [1:0] off);
	case (mode)
		modeWord: return off != 2'd0;
		modeHalf, modeHalfU: return off[0];
		default: return 1'b0;
	endcase
endfunction

// Addressed lane shifted down and extended
function automatic logic [dataWidth-1:0] laneValue(input logic [dataWidth-1:0] word,
	input accessMode_t mode, input logic [1:0] off);
	logic [7:0] b;
	logic [15:0] h;
	b = 8'(word >> (8 * off));
	h = 16'(word >> (16 * off[1]));
	case (mode)
		modeByte: return 32'($signed(b));
		modeByteU: return 32'(b);
		modeHalf: return 32'($signed(h));
		modeHalfU: return 32'(h);
		default: return word;
	endcase
endfunction

// Store merged into the shadow word
function automatic void writeLanes(input logic [addrWidth-1:0] idx, input accessMode_t mode,
	input logic [1:0] off, input logic [dataWidth-1:0] data);
	case (mode)
		modeByte, modeByteU: shadow[idx][8 * off +: 8] = data[7:0];
		modeHalf, modeHalfU: shadow[idx][16 * off[1] +: 16] = data[15:0];
		default: shadow[idx] = data;
	endcase
endfunction

// Expected packet of one request, shadow updated on a real store
function automatic wbPacket_t refPacket(input memReq_t r, input logic dbg,
	input logic [addrWidth-1:0] dAddr);
	wbPacket_t p;
	logic [addrWidth-1:0] idx;
	idx = r.byteAddr[addrWidth+1:2];
	p.kind = wbNone;
	p.destReg = r.destReg;
	p.data = '0;
	if (dbg) begin
		// Monitor read, request ignored
		p.kind = wbDebug;
		p.destReg = 5'd0;
		p.data = shadow[dAddr];
	end else if ((r.read || r.write) && sizeFault(r.mode, r.byteAddr[1:0])) begin
		p.kind = wbFault;
	end else if (r.read) begin
		// Read wins when both are set
		p.kind = wbLoad;
		p.data = laneValue(shadow[idx], r.mode, r.byteAddr[1:0]);
	end else if (r.write) begin
		writeLanes(idx, r.mode, r.byteAddr[1:0], r.writeData);
	end
	return p;
endfunction

////////////////////
// Compare tasks
////////////////////

task automatic checkKind(input string name, input wbKind_t exp, input wbKind_t act);
	if (act !== exp) begin
		kindErrors++;
		$display("ERROR %s: kind expected %s actual %s (%0d)", name, exp.name(), act.name(), act);
	end
endtask

task automatic checkPacket(input string name, input wbPacket_t exp, input wbPacket_t act);
	checkKind(name, exp.kind, act.kind);
	if (act.destReg !== exp.destReg) begin
		payloadErrors++;
		$display("ERROR %s: destReg expected %0d actual %0d", name, exp.destReg, act.destReg);
	end
	if (act.data !== exp.data) begin
		payloadErrors++;
		$display("ERROR %s: data expected %h actual %h", name, exp.data, act.data);
	end
endtask

`endif

// File: bench/memStageTb.sv
module memStageTb;
	timeunit 1ns;
	timeprecision 1ps;
	import memPkg::*;

	localparam int addrWidth = 10;
	localparam int clkPeriod = 100;
	// Test lengths that also set the watchdog limit
	localparam int poolSize = 16;
	localparam int laneIters = 8;
	localparam int extendCount = 16;
	localparam int faultIters = 4;
	localparam int debugCycles = 8;
	localparam int resumeLoads = 4;
	localparam int rwIters = 4;
	localparam int idleCycles = 4;
	localparam int totalRequests = 2 * poolSize + 4 * laneIters + 2 + extendCount
		+ 5 * faultIters + debugCycles + resumeLoads + 2 * rwIters + idleCycles;

	logic clk;
	logic rstN;
	memReq_t req;
	logic debugMode;
	logic [addrWidth-1:0] debugAddr;
	wbPacket_t wb;

	integer seed = 32'h7c75_7245;
	// Word indices used by every test
	logic [addrWidth-1:0] pool [poolSize];
	// Expected packets with test name and due time
	wbPacket_t expQ[$];
	string nameQ[$];
	time dueQ[$];
	int checked = 0;

	`include "memStageRef.svh"

	memStageTop #(
		.addrWidth(addrWidth)
	) uut (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.debugMode(debugMode),
		.debugAddr(debugAddr),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	// Upper address bits random since the DUT ignores them
	function automatic logic [31:0] addrOf(input logic [addrWidth-1:0] idx, input logic [1:0] off);
		logic [31:0] a;
		a = nextRandom();
		a[addrWidth+1:0] = {idx, off};
		return a;
	endfunction

	function automatic memReq_t makeReq(input logic rd, input logic wr, input accessMode_t mode,
		input logic [31:0] addr, input logic [dataWidth-1:0] data);
		memReq_t r;
		r.read = rd;
		r.write = wr;
		r.mode = mode;
		r.byteAddr = addr;
		r.writeData = data;
		r.destReg = 5'(nextRandom());
		return r;
	endfunction

	// One request per rising edge
	// Result due two and a half periods later
	task automatic issue(input string name, input memReq_t r, input logic dbg,
		input logic [addrWidth-1:0] dAddr);
		@(posedge clk);
		req <= r;
		debugMode <= dbg;
		debugAddr <= dAddr;
		expQ.push_back(refPacket(r, dbg, dAddr));
		nameQ.push_back(name);
		dueQ.push_back($time + 2 * clkPeriod + clkPeriod / 2);
	endtask

	task automatic load(input string name, input logic [addrWidth-1:0] idx,
		input accessMode_t mode, input logic [1:0] off);
		issue(name, makeReq(1'b1, 1'b0, mode, addrOf(idx, off), nextRandom()), 1'b0, '0);
	endtask

	task automatic store(input string name, input logic [addrWidth-1:0] idx,
		input accessMode_t mode, input logic [1:0] off, input logic [dataWidth-1:0] data);
		issue(name, makeReq(1'b0, 1'b1, mode, addrOf(idx, off), data), 1'b0, '0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		accessMode_t mode;
		logic [1:0] off;
		rstN <= 1'b0;
		req <= '0;
		debugMode <= 1'b0;
		debugAddr <= '0;
		for (int i = 0; i < poolSize; i++)
			pool[i] = addrWidth'(nextRandom());
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		// Word round trip
		for (int i = 0; i < poolSize; i++)
			store("wordStore", pool[i], modeWord, 2'd0, nextRandom());
		for (int i = 0; i < poolSize; i++)
			load("wordStore", pool[i], modeWord, 2'd0);
		// Byte lanes at every offset and halfwords at both
		for (int i = 0; i < laneIters; i++) begin
			store("laneStore", pool[i], (i % 2) ? modeByteU : modeByte, 2'(i), nextRandom());
			load("laneStore", pool[i], modeWord, 2'd0);
			mode = (i % 2) ? modeHalfU : modeHalf;
			store("laneStore", pool[i], mode, 2'(2 * ((i / 2) % 2)), nextRandom());
			load("laneStore", pool[i], modeWord, 2'd0);
		end
		// Sign bits set and clear in different lanes
		store("signExtend", pool[0], modeWord, 2'd0, 32'h80ff_7f01);
		store("signExtend", pool[1], modeWord, 2'd0, 32'h7f80_ff00);
		for (int i = 0; i < extendCount; i++) begin
			case (i % 4)
				0: mode = modeByte;
				1: mode = modeByteU;
				2: mode = modeHalf;
				default: mode = modeHalfU;
			endcase
			off = 2'(nextRandom());
			if (mode == modeHalf || mode == modeHalfU)
				off[0] = 1'b0;
			load("signExtend", pool[(i / 4) % 2], mode, off);
		end
		// Misaligned reads and writes followed by a load of the untouched word
		for (int i = 0; i < faultIters; i++) begin
			load("misaligned", pool[8 + i], (i % 2) ? modeHalfU : modeHalf, 2'(2 * (i % 2) + 1));
			load("misaligned", pool[8 + i], modeWord, 2'(i % 3 + 1));
			store("misaligned", pool[8 + i], modeHalf, 2'(2 * (i % 2) + 1), nextRandom());
			store("misaligned", pool[8 + i], modeWord, 2'(i % 3 + 1), nextRandom());
			load("misaligned", pool[8 + i], modeWord, 2'd0);
		end
		// Debug reads while req carries writes of mixed alignment
		for (int i = 0; i < debugCycles; i++) begin
			mode = (i % 2) ? modeHalf : modeWord;
			issue("debugRead", makeReq(i % 2 == 1, 1'b1, mode, addrOf(pool[i], 2'(i)), nextRandom()),
				1'b1, pool[poolSize - 1 - i]);
		end
		for (int i = 0; i < resumeLoads; i++)
			load("debugResume", pool[i], modeWord, 2'd0);
		// Read and write together only reads
		for (int i = 0; i < rwIters; i++) begin
			issue("readWrite", makeReq(1'b1, 1'b1, modeWord, addrOf(pool[12 + i], 2'd0),
				nextRandom()), 1'b0, '0);
			load("readWrite", pool[12 + i], modeWord, 2'd0);
		end
		for (int i = 0; i < idleCycles; i++)
			issue("idle", makeReq(1'b0, 1'b0, modeWord, nextRandom(), nextRandom()), 1'b0, '0);
		// Drain the pipeline
		while (dueQ.size() != 0)
			@(negedge clk);
		$display("Checked %0d packets: %0d kind errors, %0d payload errors",
			checked, kindErrors, payloadErrors);
		if (kindErrors + payloadErrors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Compare at the falling edge where wb is stable
	always @(negedge clk) begin
		wbPacket_t expPkt;
		string testName;
		if (dueQ.size() != 0 && dueQ[0] == $time) begin
			expPkt = expQ.pop_front();
			testName = nameQ.pop_front();
			void'(dueQ.pop_front());
			checkPacket(testName, expPkt, wb);
			checked++;
		end
	end

	// Watchdog
	initial begin
		#((totalRequests + 20) * clkPeriod);
		$display("Timeout: run did not finish within %0d cycles", totalRequests + 20);
		$display("sim failed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+bench
rtl/memPkg.sv
rtl/storeAligner.sv
rtl/loadExtractor.sv
rtl/dataMemory.sv
rtl/memAccessBlock.sv
rtl/memWbRegister.sv
rtl/memStageTop.sv
bench/memStageTb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := memStageTb
FILELIST := sources.f
OBJDIR   := obj_dir
LOG      := sim.log

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard bench/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
